// File: design/l2_cache_defs.svh
`ifndef L2_CACHE_DEFS_SVH
`define L2_CACHE_DEFS_SVH

`define L2_TAG_W 9
`define L2_INDEX_W 3
`define L2_OFFSET_W 4
`define L2_LINE_W 128

`define L2_WAYS 4
`define L2_SETS 8

`define PMEM_LATENCY 4 // Strobe to pmem_resp in the memory model.

`endif

// File: design/lc3b_types.sv
`default_nettype none

`include "l2_cache_defs.svh"

package lc3b_types;

typedef logic [15:0] lc3b_word;
typedef logic [`L2_TAG_W-1:0] lc3b_c2_tag;
typedef logic [`L2_INDEX_W-1:0] lc3b_c2_index;
typedef logic [`L2_LINE_W-1:0] lc3b_cache_line;
typedef logic [1:0] lc3b_way_sel;
typedef logic [2:0] lc3b_plru_bits; // Tree state, bit 0 is the root.

typedef struct packed {
	lc3b_c2_tag tag;
	lc3b_c2_index index;
	logic [`L2_OFFSET_W-1:0] offset;
} lc3b_addr_fields;

// A byte address seen either as a flat word or as its cache fields.
typedef union packed {
	lc3b_word word;
	lc3b_addr_fields fields;
} lc3b_addr_u;

endpackage : lc3b_types

`default_nettype wire

// File: design/cache_way.sv
`default_nettype none

`include "l2_cache_defs.svh"

module cache_way
	import lc3b_types::*;
(
	input wire clk,
	input wire rst_n,

	input wire write,
	input wire lc3b_c2_index index,
	input wire lc3b_c2_tag tag_in,
	input wire lc3b_cache_line data_in,
	input wire valid_in,
	input wire dirty_in,

	output logic valid,
	output logic dirty,
	output logic hit,
	output lc3b_c2_tag tag,
	output lc3b_cache_line data
);

logic [`L2_SETS-1:0] valid_q;
logic [`L2_SETS-1:0] dirty_q;
lc3b_c2_tag tag_q [`L2_SETS];
lc3b_cache_line data_q [`L2_SETS];

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		valid_q <= '0;
		dirty_q <= '0;
	end else if (write) begin
		valid_q[index] <= valid_in;
		dirty_q[index] <= dirty_in;
	end
end

always_ff @(posedge clk) begin
	if (write) begin
		tag_q[index] <= tag_in;
		data_q[index] <= data_in;
	end
end

assign valid = valid_q[index];
assign dirty = dirty_q[index];
assign tag = tag_q[index];
assign data = data_q[index];

assign hit = valid && (tag == tag_in); // Stale tags of invalid sets never match.

endmodule : cache_way

`default_nettype wire

// File: design/plru_tracker.sv
`default_nettype none

`include "l2_cache_defs.svh"

module plru_tracker
	import lc3b_types::*;
(
	input wire clk,
	input wire rst_n,

	input wire lc3b_c2_index index,
	input wire lc3b_way_sel access_way,
	input wire update,
	input wire [3:0] valid_ways,

	output lc3b_way_sel victim
);

lc3b_plru_bits plru_q [`L2_SETS];
lc3b_plru_bits cur;
lc3b_plru_bits nxt;

assign cur = plru_q[index];

// Empty ways fill first, lowest number wins.
always_comb begin
	casez (valid_ways)
		4'b???0: victim = 2'd0;
		4'b??01: victim = 2'd1;
		4'b?011: victim = 2'd2;
		4'b0111: victim = 2'd3;
		default: begin
			if (!cur[0]) begin
				victim = cur[1] ? 2'd1 : 2'd0;
			end else begin
				victim = cur[2] ? 2'd3 : 2'd2;
			end
		end
	endcase
end

// Point every node on the accessed path away from it.
always_comb begin
	nxt = cur;
	nxt[0] = ~access_way[1];
	if (!access_way[1]) begin
		nxt[1] = ~access_way[0];
	end else begin
		nxt[2] = ~access_way[0];
	end
end

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		for (int i = 0; i < `L2_SETS; i++) begin
			plru_q[i] <= '0;
		end
	end else if (update) begin
		plru_q[index] <= nxt;
	end
end

a_access_known: assert property (@(posedge clk) disable iff (!rst_n)
	update |-> !$isunknown(access_way))
	else $error("plru_tracker: access_way unknown on update");

endmodule : plru_tracker

`default_nettype wire

// File: design/l2_cache_datapath.sv
`default_nettype none

`include "l2_cache_defs.svh"

module l2_cache_datapath
	import lc3b_types::*;
(
	input wire clk,
	input wire rst_n,

	input wire load_req,
	input wire lc3b_word req_addr,
	input wire lc3b_cache_line req_wdata,

	input wire way_write,
	input wire valid_in,
	input wire dirty_in,
	input wire fill_sel,
	input wire plru_update,
	input wire wb_addr_sel,
	input wire load_resp,

	input wire lc3b_cache_line pmem_rdata,

	output logic hit,
	output logic victim_dirty,
	output lc3b_word pmem_address,
	output lc3b_cache_line pmem_wdata,
	output lc3b_cache_line resp_rdata
);

lc3b_addr_u addr_q;
lc3b_addr_u mem_addr;
lc3b_cache_line wdata_q;
lc3b_cache_line line_in;

logic [`L2_WAYS-1:0] way_valid;
logic [`L2_WAYS-1:0] way_dirty;
logic [`L2_WAYS-1:0] way_hit;
lc3b_c2_tag way_tag [`L2_WAYS];
lc3b_cache_line way_data [`L2_WAYS];

lc3b_way_sel hit_way;
lc3b_way_sel victim;
lc3b_way_sel sel_way;

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		addr_q <= '0;
	end else if (load_req) begin
		addr_q.word <= req_addr;
	end
end

always_ff @(posedge clk) begin
	if (load_req) begin
		wdata_q <= req_wdata;
	end
end

assign line_in = fill_sel ? pmem_rdata : wdata_q;

for (genvar w = 0; w < `L2_WAYS; w++) begin : g_way
	cache_way i_way
	(
		.clk,
		.rst_n,
		.write(way_write && (sel_way == lc3b_way_sel'(w))),
		.index(addr_q.fields.index),
		.tag_in(addr_q.fields.tag),
		.data_in(line_in),
		.valid_in,
		.dirty_in,
		.valid(way_valid[w]),
		.dirty(way_dirty[w]),
		.hit(way_hit[w]),
		.tag(way_tag[w]),
		.data(way_data[w])
	);
end

plru_tracker i_plru
(
	.clk,
	.rst_n,
	.index(addr_q.fields.index),
	.access_way(sel_way),
	.update(plru_update),
	.valid_ways(way_valid),
	.victim
);

always_comb begin
	hit_way = '0;
	for (int w = 0; w < `L2_WAYS; w++) begin
		if (way_hit[w]) begin
			hit_way = lc3b_way_sel'(w);
		end
	end
end

assign hit = |way_hit;
assign sel_way = hit ? hit_way : victim;

assign victim_dirty = way_valid[sel_way] && way_dirty[sel_way];
assign pmem_wdata = way_data[sel_way]; // Stable while the write strobe is held.

// Line address, with the victim tag during write-back.
always_comb begin
	mem_addr.fields.tag = wb_addr_sel ? way_tag[sel_way] : addr_q.fields.tag;
	mem_addr.fields.index = addr_q.fields.index;
	mem_addr.fields.offset = '0;
end

assign pmem_address = mem_addr.word;

// A line being written into a way is also the line returned.
always_ff @(posedge clk) begin
	if (load_resp) begin
		resp_rdata <= way_write ? line_in : way_data[sel_way];
	end
end

a_hit_onehot: assert property (@(posedge clk) disable iff (!rst_n)
	$onehot0(way_hit))
	else $error("l2_cache_datapath: more than one way hits");

endmodule : l2_cache_datapath

`default_nettype wire

// File: design/l2_cache_control.sv
`default_nettype none

module l2_cache_control
(
	input wire clk,
	input wire rst_n,

	input wire req_valid,
	input wire req_write,
	input wire resp_ready,

	input wire hit,
	input wire victim_dirty,
	input wire pmem_resp,

	output logic req_ready,
	output logic resp_valid,
	output logic pmem_read,
	output logic pmem_write,

	output logic load_req,
	output logic way_write,
	output logic valid_in,
	output logic dirty_in,
	output logic fill_sel,
	output logic plru_update,
	output logic wb_addr_sel,
	output logic load_resp
);

typedef enum logic [2:0] {
	IDLE,
	LOOKUP,
	WRITEBACK,
	FILL,
	RESPOND
} state_t;

state_t state;
state_t state_next;
logic write_q; // Request in flight is a write.

always_ff @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		state <= IDLE;
		write_q <= 1'b0;
	end else begin
		state <= state_next;
		if (load_req) begin
			write_q <= req_write;
		end
	end
end

always_comb begin
	state_next = state;
	req_ready = 1'b0;
	resp_valid = 1'b0;
	pmem_read = 1'b0;
	pmem_write = 1'b0;
	load_req = 1'b0;
	way_write = 1'b0;
	valid_in = 1'b0;
	dirty_in = 1'b0;
	fill_sel = 1'b0;
	plru_update = 1'b0;
	wb_addr_sel = 1'b0;
	load_resp = 1'b0;

	case (state)
		IDLE: begin
			req_ready = 1'b1;
			if (req_valid) begin
				load_req = 1'b1;
				state_next = LOOKUP;
			end
		end
		LOOKUP: begin
			if (hit) begin
				way_write = write_q; // Write hit overwrites the line.
				valid_in = 1'b1;
				dirty_in = 1'b1;
				plru_update = 1'b1;
				load_resp = 1'b1;
				state_next = RESPOND;
			end else if (victim_dirty) begin
				state_next = WRITEBACK;
			end else begin
				state_next = FILL;
			end
		end
		WRITEBACK: begin
			pmem_write = 1'b1;
			wb_addr_sel = 1'b1;
			if (pmem_resp) begin
				state_next = FILL;
			end
		end
		FILL: begin
			pmem_read = 1'b1;
			if (pmem_resp) begin
				way_write = 1'b1;
				valid_in = 1'b1;
				dirty_in = write_q;
				fill_sel = !write_q;
				plru_update = 1'b1;
				load_resp = 1'b1;
				state_next = RESPOND;
			end
		end
		RESPOND: begin
			resp_valid = 1'b1;
			if (resp_ready) begin
				state_next = IDLE;
			end
		end
		default: begin
			state_next = IDLE;
		end
	endcase
end

a_strobe_excl: assert property (@(posedge clk) disable iff (!rst_n)
	!(pmem_read && pmem_write))
	else $error("l2_cache_control: pmem_read and pmem_write both high");

a_strobe_hold: assert property (@(posedge clk) disable iff (!rst_n)
	(pmem_read || pmem_write) && !pmem_resp |=> $stable({pmem_read, pmem_write}))
	else $error("l2_cache_control: memory strobe dropped before pmem_resp");

a_resp_hold: assert property (@(posedge clk) disable iff (!rst_n)
	resp_valid && !resp_ready |=> resp_valid)
	else $error("l2_cache_control: resp_valid dropped before resp_ready");

endmodule : l2_cache_control

`default_nettype wire

// File: design/l2_cache.sv
`default_nettype none

module l2_cache
	import lc3b_types::*;
(
	input wire clk,
	input wire rst_n,

	input wire req_valid,
	input wire req_write,
	input wire lc3b_word req_addr,
	input wire lc3b_cache_line req_wdata,
	output logic req_ready,

	output logic resp_valid,
	output lc3b_cache_line resp_rdata,
	input wire resp_ready,

	output logic pmem_read,
	output logic pmem_write,
	output lc3b_word pmem_address,
	output lc3b_cache_line pmem_wdata,
	input wire lc3b_cache_line pmem_rdata,
	input wire pmem_resp
);

wire hit;
wire victim_dirty;
wire load_req;
wire way_write;
wire valid_in;
wire dirty_in;
wire fill_sel;
wire plru_update;
wire wb_addr_sel;
wire load_resp;

l2_cache_control i_control
(
	.clk,
	.rst_n,
	.req_valid,
	.req_write,
	.resp_ready,
	.hit,
	.victim_dirty,
	.pmem_resp,
	.req_ready,
	.resp_valid,
	.pmem_read,
	.pmem_write,
	.load_req,
	.way_write,
	.valid_in,
	.dirty_in,
	.fill_sel,
	.plru_update,
	.wb_addr_sel,
	.load_resp
);

l2_cache_datapath i_datapath
(
	.clk,
	.rst_n,
	.load_req,
	.req_addr,
	.req_wdata,
	.way_write,
	.valid_in,
	.dirty_in,
	.fill_sel,
	.plru_update,
	.wb_addr_sel,
	.load_resp,
	.pmem_rdata,
	.hit,
	.victim_dirty,
	.pmem_address,
	.pmem_wdata,
	.resp_rdata
);

endmodule : l2_cache

`default_nettype wire

// File: dv/pmem_model.sv
`default_nettype none

`include "l2_cache_defs.svh"

module pmem_model
	import lc3b_types::*;
(
	input wire clk,
	input wire rst_n,

	input wire read,
	input wire write,
	input wire lc3b_word address,
	input wire lc3b_cache_line wdata,

	output lc3b_cache_line rdata,
	output logic resp
);

lc3b_cache_line mem [4096];
int cnt;

// Every word of a line depends on its word number and the line address.
initial begin
	for (int n = 0; n < 4096; n++) begin
		for (int k = 0; k < 8; k++) begin
			mem[n][16*k +: 16] = {1'b0, 3'(k), 12'(n)} ^ 16'h9e37;
		end
	end
end

always @(posedge clk or negedge rst_n) begin
	if (!rst_n) begin
		cnt <= 0;
		resp <= 1'b0;
		rdata <= '0;
	end else if (resp) begin
		resp <= 1'b0; // One-cycle pulse.
		cnt <= 0;
	end else if (read || write) begin
		if (cnt == `PMEM_LATENCY - 1) begin
			resp <= 1'b1;
			cnt <= 0;
			if (write) begin
				mem[address[15:4]] <= wdata;
			end else begin
				rdata <= mem[address[15:4]];
			end
		end else begin
			cnt <= cnt + 1;
		end
	end
end

endmodule : pmem_model

`default_nettype wire

// File: dv/l2_cache_tb.sv
`default_nettype none

`include "l2_cache_defs.svh"

module l2_cache_tb
	import lc3b_types::*;
();

localparam int N_REQ = 240;
localparam int RESET_CYCLES = 16;
localparam int LIMIT_CYCLES = N_REQ * (2 * `PMEM_LATENCY + 10) + RESET_CYCLES + 4;

logic clk;
logic rst_n;
logic req_valid;
logic req_write;
lc3b_word req_addr;
lc3b_cache_line req_wdata;
logic req_ready;
logic resp_valid;
lc3b_cache_line resp_rdata;
logic resp_ready;
logic pmem_read;
logic pmem_write;
lc3b_word pmem_address;
lc3b_cache_line pmem_wdata;
lc3b_cache_line pmem_rdata;
logic pmem_resp;

logic [31:0] lfsr;
int mismatch_count;
int error_count;
int wb_count;

lc3b_cache_line shadow [lc3b_word];
lc3b_cache_line exp_resp [$];
lc3b_word exp_wb_addr [$];
lc3b_cache_line exp_wb_data [$];
lc3b_word wb_lines [$];
lc3b_word fill_addr;
logic fill_pending;

// Reference copy of the cache state.
lc3b_c2_tag ref_tag [8][4];
logic [3:0] ref_valid [8];
logic [3:0] ref_dirty [8];
lc3b_plru_bits ref_plru [8];

logic prev_pending;
lc3b_cache_line prev_rdata;

l2_cache i_dut
(
	.clk,
	.rst_n,
	.req_valid,
	.req_write,
	.req_addr,
	.req_wdata,
	.req_ready,
	.resp_valid,
	.resp_rdata,
	.resp_ready,
	.pmem_read,
	.pmem_write,
	.pmem_address,
	.pmem_wdata,
	.pmem_rdata,
	.pmem_resp
);

pmem_model i_mem
(
	.clk,
	.rst_n,
	.read(pmem_read),
	.write(pmem_write),
	.address(pmem_address),
	.wdata(pmem_wdata),
	.rdata(pmem_rdata),
	.resp(pmem_resp)
);

always #20 clk = ~clk;

function automatic logic [31:0] lfsr_step(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // Taps 32, 22, 2, 1.
endfunction

function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		lfsr = lfsr_step(lfsr);
		v = {v[30:0], lfsr[0]};
	end
	return v;
endfunction

function automatic lc3b_cache_line rand_line();
	lc3b_cache_line l;
	for (int i = 0; i < 4; i++) begin
		l[32*i +: 32] = rand_bits(32);
	end
	return l;
endfunction

function automatic lc3b_word make_addr(input lc3b_c2_tag t, input lc3b_c2_index i,
		input logic [3:0] o);
	lc3b_addr_u a;
	a.fields.tag = t;
	a.fields.index = i;
	a.fields.offset = o;
	return a.word;
endfunction

function automatic lc3b_cache_line cold_line(input lc3b_word addr);
	lc3b_cache_line l;
	for (int k = 0; k < 8; k++) begin
		l[16*k +: 16] = {1'b0, 3'(k), addr[15:4]} ^ 16'h9e37;
	end
	return l;
endfunction

function automatic lc3b_cache_line expected_line(input lc3b_word addr);
	lc3b_word key;
	key = {addr[15:4], 4'h0};
	if (shadow.exists(key)) begin
		return shadow[key];
	end
	return cold_line(key);
endfunction

// Lowest invalid way first, otherwise follow the tree.
function automatic lc3b_way_sel plru_victim(input lc3b_plru_bits b, input logic [3:0] v);
	for (int w = 0; w < 4; w++) begin
		if (!v[w]) begin
			return lc3b_way_sel'(w);
		end
	end
	if (!b[0]) begin
		return b[1] ? 2'd1 : 2'd0;
	end
	return b[2] ? 2'd3 : 2'd2;
endfunction

// Bits {ways 2/3, ways 0/1, root} end up pointing away from the touched way.
function automatic lc3b_plru_bits plru_touch(input lc3b_plru_bits b, input lc3b_way_sel w);
	lc3b_plru_bits n;
	case (w)
		2'd0: n = {b[2], 2'b11};
		2'd1: n = {b[2], 2'b01};
		2'd2: n = {1'b1, b[1], 1'b0};
		default: n = {1'b0, b[1], 1'b0};
	endcase
	return n;
endfunction

function automatic logic line_dirty(input lc3b_word addr);
	lc3b_addr_u a;
	a.word = addr;
	for (int w = 0; w < 4; w++) begin
		if (ref_valid[a.fields.index][w] && ref_dirty[a.fields.index][w]
				&& ref_tag[a.fields.index][w] == a.fields.tag) begin
			return 1'b1;
		end
	end
	return 1'b0;
endfunction

task automatic check_line(input string name, input lc3b_cache_line got,
		input lc3b_cache_line exp);
	if (got !== exp) begin
		mismatch_count++;
		$display("MISMATCH %s got %h expected %h", name, got, exp);
	end
endtask

task automatic check_addr(input string name, input lc3b_word got, input lc3b_word exp);
	if (got !== exp) begin
		mismatch_count++;
		$display("MISMATCH %s got %h expected %h", name, got, exp);
	end
endtask

task automatic report_error(input string what);
	error_count++;
	$display("ERROR at %0t: %s", $time, what);
endtask

// Predicts hit, eviction and write-back for one request.
task automatic model_access(input lc3b_word addr, input logic wr, output logic hit);
	lc3b_addr_u a;
	lc3b_addr_u v;
	int idx;
	lc3b_way_sel way;
	a.word = addr;
	idx = int'(a.fields.index);
	hit = 1'b0;
	way = '0;
	for (int w = 0; w < 4; w++) begin
		if (ref_valid[idx][w] && ref_tag[idx][w] == a.fields.tag) begin
			hit = 1'b1;
			way = lc3b_way_sel'(w);
		end
	end
	if (hit) begin
		if (wr) begin
			ref_dirty[idx][way] = 1'b1;
		end
	end else begin
		way = plru_victim(ref_plru[idx], ref_valid[idx]);
		if (ref_valid[idx][way] && ref_dirty[idx][way]) begin
			v.fields.tag = ref_tag[idx][way];
			v.fields.index = a.fields.index;
			v.fields.offset = '0;
			exp_wb_addr.push_back(v.word);
			exp_wb_data.push_back(expected_line(v.word));
		end
		ref_tag[idx][way] = a.fields.tag;
		ref_valid[idx][way] = 1'b1;
		ref_dirty[idx][way] = wr;
	end
	ref_plru[idx] = plru_touch(ref_plru[idx], way);
endtask

// Called 2 units after a rising edge, returns at the same point.
task automatic issue(input logic wr, input lc3b_word addr, input lc3b_cache_line data,
		input logic bp);
	logic hit;
	int lat;
	model_access(addr, wr, hit);
	fill_pending = !hit;
	fill_addr = {addr[15:4], 4'h0};
	exp_resp.push_back(wr ? data : expected_line(addr));
	if (wr) begin
		shadow[{addr[15:4], 4'h0}] = data;
	end
	req_valid = 1'b1;
	req_write = wr;
	req_addr = addr;
	req_wdata = data;
	resp_ready = bp ? (rand_bits(1) == 32'd1) : 1'b1;
	do begin
		@(negedge clk);
	end while (!req_ready);
	@(posedge clk);
	#2;
	req_valid = 1'b0;
	req_write = 1'b0;
	lat = 0;
	do begin
		@(negedge clk);
		lat++;
	end while (!resp_valid);
	if (hit && lat != 2) begin
		report_error($sformatf("hit response came %0d cycles after acceptance", lat));
	end
	while (!(resp_valid && resp_ready)) begin
		@(posedge clk);
		#2;
		resp_ready = bp ? (rand_bits(1) == 32'd1) : 1'b1;
		@(negedge clk);
	end
	@(posedge clk);
	#2;
	resp_ready = 1'b1;
	if (exp_wb_addr.size() != 0) begin
		report_error("an expected write-back did not happen");
		exp_wb_addr.delete();
		exp_wb_data.delete();
	end
	if (fill_pending) begin
		report_error("an expected line fill did not happen");
		fill_pending = 1'b0;
	end
endtask

task automatic random_req(input logic [1:0] idx_base, input logic bp);
	logic wr;
	lc3b_word addr;
	wr = rand_bits(1) == 32'd1;
	addr = make_addr({6'h2a, 3'(rand_bits(3))}, {1'b0, idx_base} + 3'(rand_bits(1)),
		4'(rand_bits(4)));
	issue(wr, addr, wr ? rand_line() : '0, bp);
endtask

// Responses and write-backs are compared where they are stable.
always @(negedge clk) begin : compare_proc
	if (rst_n) begin
		if (resp_valid && req_ready) begin
			report_error("req_ready high while a response is pending");
		end
		if (resp_valid && prev_pending) begin
			check_line("resp_rdata held", resp_rdata, prev_rdata);
		end
		if (resp_valid && resp_ready) begin
			if (exp_resp.size() == 0) begin
				report_error("response with no request outstanding");
			end else begin
				check_line("resp_rdata", resp_rdata, exp_resp.pop_front());
			end
		end
		prev_pending = resp_valid && !resp_ready;
		prev_rdata = resp_rdata;
		if (pmem_write && pmem_resp) begin
			wb_count++;
			wb_lines.push_back(pmem_address);
			if (exp_wb_addr.size() == 0) begin
				report_error("unexpected write-back to memory");
			end else begin
				check_addr("pmem_address", pmem_address, exp_wb_addr.pop_front());
				check_line("pmem_wdata", pmem_wdata, exp_wb_data.pop_front());
			end
		end
		if (pmem_read && pmem_resp) begin
			if (!fill_pending) begin
				report_error("line fill from memory where none was expected");
			end else begin
				check_addr("pmem_address", pmem_address, fill_addr);
				fill_pending = 1'b0;
			end
		end
	end
end

initial begin : watchdog
	repeat (LIMIT_CYCLES) @(posedge clk);
	$display("Watchdog timeout, the run did not finish in %0d cycles", LIMIT_CYCLES);
	$display("Test failed");
	$finish;
end

initial begin
	int wb_start;
	clk = 1'b0;
	rst_n = 1'b0;
	req_valid = 1'b0;
	req_write = 1'b0;
	req_addr = '0;
	req_wdata = '0;
	resp_ready = 1'b1;
	lfsr = 32'h68089f7a;
	mismatch_count = 0;
	error_count = 0;
	wb_count = 0;
	fill_pending = 1'b0;
	fill_addr = '0;
	prev_pending = 1'b0;
	prev_rdata = '0;
	for (int s = 0; s < 8; s++) begin
		ref_valid[s] = '0;
		ref_dirty[s] = '0;
		ref_plru[s] = '0;
	end
	repeat (RESET_CYCLES) @(posedge clk);
	#2;
	rst_n = 1'b1;
	@(posedge clk);
	#2;

	issue(1'b0, make_addr(9'h011, 3'd1, 4'h0), '0, 1'b0); // Cold read miss.

	issue(1'b1, make_addr(9'h0a2, 3'd2, 4'h4), rand_line(), 1'b0);
	issue(1'b0, make_addr(9'h0a2, 3'd2, 4'h8), '0, 1'b0);

	wb_start = wb_count; // Five tags into one set.
	for (int t = 0; t < 5; t++) begin
		issue(1'b1, make_addr(9'h100 + 9'(t), 3'd5, 4'h0), rand_line(), 1'b0);
	end
	if (wb_count - wb_start != 1) begin
		report_error($sformatf("%0d write-backs for five tags, one expected",
			wb_count - wb_start));
	end

	issue(1'b0, make_addr(9'h103, 3'd5, 4'h0), '0, 1'b0);
	issue(1'b0, make_addr(9'h101, 3'd5, 4'h0), '0, 1'b0);
	issue(1'b0, make_addr(9'h104, 3'd5, 4'h0), '0, 1'b0);
	issue(1'b1, make_addr(9'h1f0, 3'd5, 4'h0), rand_line(), 1'b0);

	repeat (24) random_req(2'd3, 1'b1); // Back-pressure on sets 3 and 4.
	repeat (200) random_req(2'd0, 1'b0);

	foreach (wb_lines[i]) begin
		if (!line_dirty(wb_lines[i])) begin
			check_line("pmem line", i_mem.mem[wb_lines[i][15:4]], expected_line(wb_lines[i]));
		end
	end

	$display("Done: %0d mismatches, %0d other errors, %0d write-backs",
		mismatch_count, error_count, wb_count);
	if (mismatch_count == 0 && error_count == 0) begin
		$display("Test passed");
	end else begin
		$display("Test failed");
	end
	$finish;
end

endmodule : l2_cache_tb

`default_nettype wire

// File: sources.f
+incdir+design
design/lc3b_types.sv
design/cache_way.sv
design/plru_tracker.sv
design/l2_cache_datapath.sv
design/l2_cache_control.sv
design/l2_cache.sv
dv/pmem_model.sv
dv/l2_cache_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
TOP       ?= l2_cache_tb
FILELIST  ?= sources.f
LOG       ?= sim.log

OBJ_DIR := obj_dir
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test passed" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
